// File: Bender.yml
package:
  name: fetch_front_end

sources:
  - files:
      - fetch_pkg.sv
      - pc_gen.sv
      - fetch_stage.sv
      - fetch_apb_master.sv
      - apb_arbiter.sv
      - imem_apb.sv
      - fetch_top.sv
  - target: test
    files:
      - tb_fetch_top.sv

// File: apb_arbiter.sv
////////////////////////////////////////////////////////////
// Loader wins at a setup phase, grant held to pready
// A late requester gets a fresh setup phase toward the memory
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module apb_arbiter (
	input  wire                   clk,
	input  wire                   reset_i,
	// Loader side
	input  fetch_pkg::apb_req_t   ld_req_i,
	output fetch_pkg::apb_rsp_t   ld_rsp_o,
	// Fetch master side
	input  fetch_pkg::apb_req_t   fe_req_i,
	output fetch_pkg::apb_rsp_t   fe_rsp_o,
	output fetch_pkg::fetch_tag_e fe_tag_o,
	// Memory side
	output fetch_pkg::apb_req_t   mem_req_o,
	input  fetch_pkg::apb_rsp_t   mem_rsp_i,
	input  fetch_pkg::fetch_tag_e mem_tag_i
);

	// Transfer in progress, owner in grant_q (1 = loader)
	logic busy_q;
	logic grant_q;
	logic own_ld;

	// Between transfers the loader wins whenever it asks
	assign own_ld = busy_q ? grant_q : ld_req_i.psel;

	////////////////////////////////////////////////////////////
	// Request mux
	////////////////////////////////////////////////////////////
	always_comb begin
		mem_req_o = own_ld ? ld_req_i : fe_req_i;
		// First granted cycle is always a setup phase
		if (!busy_q) mem_req_o.penable = 1'b0;
	end

	always_ff @(posedge clk) begin
		if (reset_i) begin
			busy_q  <= 1'b0;
			grant_q <= 1'b0;
		end else if (!busy_q) begin
			busy_q  <= mem_req_o.psel;
			grant_q <= own_ld;
		end else if (mem_rsp_i.pready) begin
			busy_q <= 1'b0;
		end
	end

	////////////////////////////////////////////////////////////
	// Response routing, loser sees pready low
	////////////////////////////////////////////////////////////
	always_comb begin
		ld_rsp_o         = mem_rsp_i;
		ld_rsp_o.pready  = mem_rsp_i.pready & busy_q & grant_q;
		ld_rsp_o.pslverr = mem_rsp_i.pslverr & busy_q & grant_q;
		fe_rsp_o         = mem_rsp_i;
		fe_rsp_o.pready  = mem_rsp_i.pready & busy_q & ~grant_q;
		fe_rsp_o.pslverr = mem_rsp_i.pslverr & busy_q & ~grant_q;
	end

	// Tag only meaningful for the fetch owner
	assign fe_tag_o = (busy_q & ~grant_q) ? mem_tag_i : fetch_pkg::TAG_NONE;

	// Owner fixed until the memory completes
	grant_hold_a: assert property (
		@(posedge clk) disable iff (reset_i)
		(busy_q && mem_req_o.psel && !mem_rsp_i.pready) |=> (busy_q && $stable(grant_q))
	);

endmodule

`default_nettype wire

// File: fetch_apb_master.sv
////////////////////////////////////////////////////////////
// One APB read per fetch address, never more than one in flight
// start_i marks the previous word consumed; a flush restarts fetch
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module fetch_apb_master (
	input  wire                          clk,
	input  wire                          reset_i,
	input  wire [fetch_pkg::ADDR_W-1:0]  pc_i,
	input  wire                          start_i,
	input  wire                          flush_i,
	output fetch_pkg::apb_req_t          req_o,
	input  fetch_pkg::apb_rsp_t          rsp_i,
	input  fetch_pkg::fetch_tag_e        tag_i,
	output logic                         ack_o,
	output logic                         err_o,
	output fetch_pkg::fetch_tag_e        tag_o,
	output logic [31:0]                  data_o,
	output logic                         busy_o
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_SETUP,
		ST_ACCESS
	} state_e;

	state_e                       state_q;
	logic                         need_q;
	logic                         drop_q;
	logic [fetch_pkg::ADDR_W-1:0] addr_q;
	logic                         issue;
	logic                         done;

	// Wait one cycle after a flush so pc_i holds the target
	assign issue = (state_q == ST_IDLE) & need_q & ~flush_i;
	assign done  = (state_q == ST_ACCESS) & rsp_i.pready;

	////////////////////////////////////////////////////////////
	// Transfer FSM
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (reset_i) begin
			state_q <= ST_IDLE;
			need_q  <= 1'b1;
			drop_q  <= 1'b0;
		end else begin
			case (state_q)
				ST_IDLE:   if (issue) state_q <= ST_SETUP;
				ST_SETUP:  state_q <= ST_ACCESS;
				ST_ACCESS: if (rsp_i.pready) state_q <= ST_IDLE;
				default:   state_q <= ST_IDLE;
			endcase
			// Pending request for the next word
			need_q <= start_i | flush_i | (need_q & ~issue);
			// Stale word from before a flush
			drop_q <= (drop_q | (flush_i & (state_q != ST_IDLE))) & ~done;
		end
	end

	// Address frozen for the whole transfer
	always_ff @(posedge clk) begin
		if (issue) addr_q <= pc_i;
	end

	always_comb begin
		req_o         = '0;
		req_o.paddr   = addr_q;
		req_o.psel    = (state_q != ST_IDLE);
		req_o.penable = (state_q == ST_ACCESS);
	end

	assign ack_o  = done & ~rsp_i.pslverr & ~drop_q & ~flush_i;
	assign err_o  = done & rsp_i.pslverr & ~drop_q & ~flush_i;
	assign tag_o  = tag_i;
	assign data_o = rsp_i.prdata;
	assign busy_o = (state_q != ST_IDLE);

	// Request held through the access phase until pready
	req_stable_a: assert property (
		@(posedge clk) disable iff (reset_i)
		(req_o.psel && req_o.penable && !rsp_i.pready) |=> $stable(req_o)
	);

endmodule

`default_nettype wire

// File: fetch_pkg.sv
////////////////////////////////////////////////////////////
// Shared types for the fetch front end, 32-bit addresses only
// APB structs carry no pprot or pstrb, every access is a full word
////////////////////////////////////////////////////////////
`default_nettype none

package fetch_pkg;

	// Bus address width
	localparam int ADDR_W = 32;

	// Instruction forced whenever no real word is presented
	localparam logic [31:0] NOP_INSN = {6'b000101, 26'h041_0000};

	////////////////////////////////////////////////////////////
	// APB request and response
	////////////////////////////////////////////////////////////
	typedef struct packed {
		logic [ADDR_W-1:0] paddr;
		logic [31:0]       pwdata;
		logic              psel;
		logic              penable;
		logic              pwrite;
	} apb_req_t;

	typedef struct packed {
		logic [31:0] prdata;
		logic        pready;
		logic        pslverr;
	} apb_rsp_t;

	// Cause of a pslverr, valid only alongside it
	typedef enum logic [1:0] {
		TAG_NONE = 2'd0,
		TAG_BUS  = 2'd1,
		TAG_PROT = 2'd2
	} fetch_tag_e;

	// Result handed to the core
	typedef struct packed {
		logic [31:0]       insn;
		logic [ADDR_W-1:0] pc;
		logic              valid;
		logic              except_bus;
		logic              except_prot;
	} fetch_out_t;

endpackage

`default_nettype wire

// File: fetch_stage.sv
////////////////////////////////////////////////////////////
// Holds one returned word while the pipeline is frozen
// Fetch must not return a second word while one is saved
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module fetch_stage (
	input  wire                          clk,
	input  wire                          reset_i,
	input  wire                          freeze_i,
	input  wire                          flush_i,
	input  wire                          squash_i,
	// One-cycle response from the fetch master
	input  wire                          bus_ack_i,
	input  wire                          bus_err_i,
	input  fetch_pkg::fetch_tag_e        bus_tag_i,
	input  wire [31:0]                   bus_data_i,
	input  wire [fetch_pkg::ADDR_W-1:0]  pc_i,
	output fetch_pkg::fetch_out_t        out_o,
	output logic                         adv_o,
	output logic                         stall_o
);

	logic                         resp;
	logic                         save;
	logic                         force_nop;
	logic                         live_bus;
	logic                         live_prot;
	// Saved state
	logic                         saved_q;
	logic                         bypass_q;
	logic                         err_bus_q;
	logic                         err_prot_q;
	logic [31:0]                  insn_q;
	logic [fetch_pkg::ADDR_W-1:0] addr_q;

	assign resp = bus_ack_i | bus_err_i;
	// Capture only the first word seen while frozen
	assign save = resp & freeze_i & ~saved_q & ~flush_i;

	// Error causes of the live response
	assign live_bus  = bus_err_i & (bus_tag_i == fetch_pkg::TAG_BUS);
	assign live_prot = bus_err_i & (bus_tag_i == fetch_pkg::TAG_PROT);

	// No-op on squash, flush, or bypass with nothing new
	assign force_nop = squash_i | flush_i | (bypass_q & ~resp);

	////////////////////////////////////////////////////////////
	// Saved flag, bypass and error flags
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (reset_i) begin
			saved_q    <= 1'b0;
			bypass_q   <= 1'b0;
			err_bus_q  <= 1'b0;
			err_prot_q <= 1'b0;
		end else begin
			// Bypass stays until the next response
			bypass_q <= flush_i | (bypass_q & ~resp);
			if (flush_i) begin
				saved_q    <= 1'b0;
				err_bus_q  <= 1'b0;
				err_prot_q <= 1'b0;
			end else if (save) begin
				saved_q    <= 1'b1;
				err_bus_q  <= live_bus;
				err_prot_q <= live_prot;
			end else if (!freeze_i) begin
				// Released word was consumed this cycle
				saved_q <= 1'b0;
			end
		end
	end

	// Saved word and its address
	always_ff @(posedge clk) begin
		if (save) begin
			insn_q <= bus_err_i ? fetch_pkg::NOP_INSN : bus_data_i;
			addr_q <= pc_i;
		end
	end

	////////////////////////////////////////////////////////////
	// Result toward the core
	////////////////////////////////////////////////////////////
	always_comb begin
		out_o.valid = ~flush_i & (saved_q | resp);
		out_o.pc    = saved_q ? addr_q : pc_i;
		if (force_nop) begin
			out_o.insn = fetch_pkg::NOP_INSN;
		end else if (saved_q) begin
			out_o.insn = insn_q;
		end else if (bus_ack_i) begin
			out_o.insn = bus_data_i;
		end else begin
			// Faulted or nothing returned yet
			out_o.insn = fetch_pkg::NOP_INSN;
		end
		out_o.except_bus  = ~squash_i & ~flush_i & (saved_q ? err_bus_q : live_bus);
		out_o.except_prot = ~squash_i & ~flush_i & (saved_q ? err_prot_q : live_prot);
	end

	// Word leaves the stage once the core is not frozen
	assign adv_o   = out_o.valid & ~freeze_i;
	// Core waits, no word available
	assign stall_o = ~out_o.valid;

	save_sets_a: assert property (
		@(posedge clk) disable iff (reset_i)
		save |=> saved_q
	);

	flush_clears_a: assert property (
		@(posedge clk) disable iff (reset_i)
		flush_i |=> !saved_q
	);

	squash_no_exc_a: assert property (
		@(posedge clk) disable iff (reset_i)
		squash_i |-> (!out_o.except_bus && !out_o.except_prot)
	);

endmodule

`default_nettype wire

// File: fetch_top.sv
////////////////////////////////////////////////////////////
// Fetch front end with a shared instruction memory
// Loader port is an APB slave, loader wins arbitration
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module fetch_top #(
	parameter logic [fetch_pkg::ADDR_W-1:0] RESET_PC    = '0,
	parameter int                           MEM_WORDS   = 64,
	parameter int                           WAIT_STATES = 1,
	parameter logic [fetch_pkg::ADDR_W-1:0] PROT_BASE   = 32'h0000_00c0,
	parameter int                           PROT_WORDS  = 4
) (
	input  wire                         clk,
	input  wire                         reset_i,
	input  fetch_pkg::apb_req_t         ld_req_i,
	output fetch_pkg::apb_rsp_t         ld_rsp_o,
	input  wire                         freeze_i,
	// Flush also redirects fetch to the target
	input  wire                         flush_i,
	input  wire [fetch_pkg::ADDR_W-1:0] redirect_target_i,
	input  wire                         squash_i,
	output fetch_pkg::fetch_out_t       fetch_o,
	output logic                        stall_o
);

	logic [fetch_pkg::ADDR_W-1:0] pc;
	logic                         fetch_adv;
	// Fetch master to stage
	logic                         bus_ack;
	logic                         bus_err;
	fetch_pkg::fetch_tag_e        bus_tag;
	logic [31:0]                  bus_data;
	// APB side
	fetch_pkg::apb_req_t          fe_req;
	fetch_pkg::apb_rsp_t          fe_rsp;
	fetch_pkg::fetch_tag_e        fe_tag;
	fetch_pkg::apb_req_t          mem_req;
	fetch_pkg::apb_rsp_t          mem_rsp;
	fetch_pkg::fetch_tag_e        mem_tag;

	pc_gen #(.RESET_PC(RESET_PC)) pc_gen_inst (
		.clk(clk), .reset_i(reset_i), .adv_i(fetch_adv),
		.redirect_i(flush_i), .target_i(redirect_target_i), .pc_o(pc)
	);

	fetch_apb_master fetch_apb_master_inst (
		.clk(clk), .reset_i(reset_i), .pc_i(pc), .start_i(fetch_adv),
		.flush_i(flush_i), .req_o(fe_req), .rsp_i(fe_rsp), .tag_i(fe_tag),
		.ack_o(bus_ack), .err_o(bus_err), .tag_o(bus_tag), .data_o(bus_data),
		.busy_o()
	);

	fetch_stage fetch_stage_inst (
		.clk(clk), .reset_i(reset_i), .freeze_i(freeze_i), .flush_i(flush_i),
		.squash_i(squash_i), .bus_ack_i(bus_ack), .bus_err_i(bus_err),
		.bus_tag_i(bus_tag), .bus_data_i(bus_data), .pc_i(pc),
		.out_o(fetch_o), .adv_o(fetch_adv), .stall_o(stall_o)
	);

	apb_arbiter apb_arbiter_inst (
		.clk(clk), .reset_i(reset_i), .ld_req_i(ld_req_i), .ld_rsp_o(ld_rsp_o),
		.fe_req_i(fe_req), .fe_rsp_o(fe_rsp), .fe_tag_o(fe_tag),
		.mem_req_o(mem_req), .mem_rsp_i(mem_rsp), .mem_tag_i(mem_tag)
	);

	imem_apb #(
		.MEM_WORDS(MEM_WORDS), .WAIT_STATES(WAIT_STATES),
		.PROT_BASE(PROT_BASE), .PROT_WORDS(PROT_WORDS)
	) imem_apb_inst (
		.clk(clk), .reset_i(reset_i), .req_i(mem_req), .rsp_o(mem_rsp), .tag_o(mem_tag)
	);

endmodule

`default_nettype wire

// File: filelist.f
fetch_pkg.sv
pc_gen.sv
fetch_stage.sv
fetch_apb_master.sv
apb_arbiter.sv
imem_apb.sv
fetch_top.sv
tb_fetch_top.sv

// File: imem_apb.sv
////////////////////////////////////////////////////////////
// Word memory, byte lanes ignored, no reset of contents
// Reads in the no-execute window fault, writes there succeed
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module imem_apb #(
	parameter int                           MEM_WORDS   = 64,
	parameter int                           WAIT_STATES = 0,
	parameter logic [fetch_pkg::ADDR_W-1:0] PROT_BASE   = '0,
	parameter int                           PROT_WORDS  = 0
) (
	input  wire                   clk,
	input  wire                   reset_i,
	input  fetch_pkg::apb_req_t   req_i,
	output fetch_pkg::apb_rsp_t   rsp_o,
	output fetch_pkg::fetch_tag_e tag_o
);

	localparam int IDX_W = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;
	localparam int CNT_W = (WAIT_STATES > 0) ? $clog2(WAIT_STATES + 1) : 1;
	localparam logic [fetch_pkg::ADDR_W-1:0] MEM_END = MEM_WORDS * 4;
	localparam logic [fetch_pkg::ADDR_W-1:0] PROT_END = PROT_BASE + PROT_WORDS * 4;

	logic [31:0]      mem_q [MEM_WORDS];
	logic [CNT_W-1:0] wait_q;
	logic [IDX_W-1:0] idx;
	logic             access;
	logic             done;
	logic             out_of_range;
	logic             no_exec;

	assign idx    = req_i.paddr[IDX_W+1:2];
	assign access = req_i.psel & req_i.penable;
	// pready after WAIT_STATES extra access cycles
	assign done   = access & (wait_q == CNT_W'(WAIT_STATES));

	// Error checks
	assign out_of_range = (req_i.paddr >= MEM_END);
	assign no_exec = ~req_i.pwrite & (req_i.paddr >= PROT_BASE) & (req_i.paddr < PROT_END);

	always_ff @(posedge clk) begin
		if (reset_i) begin
			wait_q <= '0;
		end else if (access && !done) begin
			wait_q <= wait_q + 1'b1;
		end else begin
			wait_q <= '0;
		end
	end

	// Store on the completing cycle only
	always_ff @(posedge clk) begin
		if (done && req_i.pwrite && !out_of_range) mem_q[idx] <= req_i.pwdata;
	end

	assign rsp_o.pready  = done;
	assign rsp_o.pslverr = done & (out_of_range | no_exec);
	assign rsp_o.prdata  = (done & ~out_of_range & ~req_i.pwrite) ? mem_q[idx] : '0;

	// Range error outranks the window
	assign tag_o = !done       ? fetch_pkg::TAG_NONE :
	               out_of_range ? fetch_pkg::TAG_BUS  :
	               no_exec      ? fetch_pkg::TAG_PROT : fetch_pkg::TAG_NONE;

endmodule

`default_nettype wire

// File: pc_gen.sv
////////////////////////////////////////////////////////////
// Fetch address register, always word aligned
// Redirect wins over a step in the same cycle
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module pc_gen #(
	parameter logic [fetch_pkg::ADDR_W-1:0] RESET_PC = '0
) (
	input  wire                          clk,
	input  wire                          reset_i,
	// Current word consumed
	input  wire                          adv_i,
	// Load target on the next edge
	input  wire                          redirect_i,
	input  wire [fetch_pkg::ADDR_W-1:0]  target_i,
	output logic [fetch_pkg::ADDR_W-1:0] pc_o
);

	// Word address only, low two bits are implied zero
	logic [fetch_pkg::ADDR_W-3:0] word_q;

	////////////////////////////////////////////////////////////
	// Address update
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (reset_i) begin
			word_q <= RESET_PC[fetch_pkg::ADDR_W-1:2];
		end else if (redirect_i) begin
			// Low bits of the target are dropped
			word_q <= target_i[fetch_pkg::ADDR_W-1:2];
		end else if (adv_i) begin
			// Next sequential word
			word_q <= word_q + 1'b1;
		end
	end

	assign pc_o = {word_q, 2'b00};

	// Core never sees a misaligned fetch address
	pc_aligned_a: assert property (
		@(posedge clk) disable iff (reset_i)
		pc_o[1:0] == 2'b00
	);

endmodule

`default_nettype wire

// File: tb_fetch_top.sv
////////////////////////////////////////////////////////////
// Directed testbench for the fetch front end
// Program words come from a Galois LFSR, stops at the first error
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module tb_fetch_top;

	localparam logic [31:0] RESET_PC    = 32'h0;
	localparam int          MEM_WORDS   = 64;
	localparam int          WAIT_STATES = 1;
	localparam logic [31:0] PROT_BASE   = 32'h0000_00c0;
	localparam int          PROT_WORDS  = 4;
	localparam logic [31:0] LFSR_SEED   = 32'h692b;
	localparam logic [31:0] LFSR_TAPS   = 32'h8020_0003;
	// Cycle limits for each wait loop
	localparam int          FETCH_TIMEOUT = 100;
	localparam int          BUS_TIMEOUT   = 100;

	logic                  clk;
	logic                  reset_i;
	fetch_pkg::apb_req_t   ld_req;
	fetch_pkg::apb_rsp_t   ld_rsp;
	logic                  freeze;
	logic                  flush;
	logic [31:0]           target;
	logic                  squash;
	fetch_pkg::fetch_out_t fetch_out;
	logic                  stall;
	logic [31:0]           lfsr_q;
	// Words loaded at address 0
	logic [31:0]           prog [16];

	fetch_top #(
		.RESET_PC(RESET_PC), .MEM_WORDS(MEM_WORDS), .WAIT_STATES(WAIT_STATES),
		.PROT_BASE(PROT_BASE), .PROT_WORDS(PROT_WORDS)
	) fetch_top_inst (
		.clk(clk), .reset_i(reset_i), .ld_req_i(ld_req), .ld_rsp_o(ld_rsp),
		.freeze_i(freeze), .flush_i(flush), .redirect_target_i(target),
		.squash_i(squash), .fetch_o(fetch_out), .stall_o(stall)
	);

	initial clk = 1'b0;
	always #50 clk = ~clk;

	////////////////////////////////////////////////////////////
	// Helpers
	////////////////////////////////////////////////////////////
	task automatic fail_run(input string why);
		$display("%s", why);
		$display("sim failed");
		$fatal(1);
	endtask

	// Drive point, just after the rising edge
	task automatic next_cycle();
		@(posedge clk);
		#1;
	endtask

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		logic [31:0] n;
		n = s >> 1;
		if (s[0]) n = n ^ LFSR_TAPS;
		return n;
	endfunction

	// One LFSR step per bit taken
	task automatic draw_word(output logic [31:0] w);
		w = '0;
		for (int b = 0; b < 32; b++) begin
			w = {w[30:0], lfsr_q[0]};
			lfsr_q = lfsr_next(lfsr_q);
		end
	endtask

	// Expected fetch result for an address, from the memory map
	function automatic fetch_pkg::fetch_out_t expect_at(input logic [31:0] addr);
		fetch_pkg::fetch_out_t e;
		e       = '0;
		e.valid = 1'b1;
		e.pc    = addr;
		e.insn  = fetch_pkg::NOP_INSN;
		if (addr >= MEM_WORDS * 4) begin
			e.except_bus = 1'b1;
		end else if (addr >= PROT_BASE && addr < PROT_BASE + PROT_WORDS * 4) begin
			e.except_prot = 1'b1;
		end else begin
			e.insn = prog[addr[5:2]];
		end
		return e;
	endfunction

	task automatic compare_out(input string name, input fetch_pkg::fetch_out_t exp,
			input fetch_pkg::fetch_out_t act);
		string exp_s;
		string act_s;
		if (act !== exp) begin
			exp_s = $sformatf("pc %h insn %h v/bus/prot %b%b%b",
				exp.pc, exp.insn, exp.valid, exp.except_bus, exp.except_prot);
			act_s = $sformatf("pc %h insn %h v/bus/prot %b%b%b",
				act.pc, act.insn, act.valid, act.except_bus, act.except_prot);
			fail_run({"error ", name, " expected ", exp_s, " actual ", act_s});
		end
	endtask

	task automatic compare_rsp(input string name, input fetch_pkg::apb_rsp_t exp,
			input fetch_pkg::apb_rsp_t act);
		if (act !== exp) begin
			fail_run($sformatf("error %s expected prdata %h err %b actual prdata %h err %b",
				name, exp.prdata, exp.pslverr, act.prdata, act.pslverr));
		end
	endtask

	task automatic compare_stall(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			fail_run($sformatf("error %s expected stall %b actual %b", name, exp, act));
		end
	endtask

	// Sampled at the falling edge, one valid result
	task automatic wait_fetch(input string name, output fetch_pkg::fetch_out_t res);
		int n;
		n = 0;
		@(negedge clk);
		while (!fetch_out.valid) begin
			n++;
			if (n > FETCH_TIMEOUT) begin
				fail_run($sformatf("timeout in %s, no valid fetch result arrived", name));
			end
			@(negedge clk);
		end
		res = fetch_out;
		// A presented word never stalls the core
		compare_stall(name, 1'b0, stall);
	endtask

	////////////////////////////////////////////////////////////
	// Loader port, APB setup then access until pready
	////////////////////////////////////////////////////////////
	task automatic loader_xfer(input logic wr, input logic [31:0] addr,
			input logic [31:0] data, output fetch_pkg::apb_rsp_t rsp);
		int n;
		next_cycle();
		ld_req.paddr   = addr;
		ld_req.pwdata  = data;
		ld_req.pwrite  = wr;
		ld_req.psel    = 1'b1;
		ld_req.penable = 1'b0;
		next_cycle();
		ld_req.penable = 1'b1;
		n = 0;
		@(negedge clk);
		// Loader may wait behind a fetch transfer
		while (!ld_rsp.pready) begin
			n++;
			if (n > BUS_TIMEOUT) begin
				fail_run($sformatf("timeout, loader transfer at %h got no pready", addr));
			end
			@(negedge clk);
		end
		rsp = ld_rsp;
		next_cycle();
		ld_req = '0;
	endtask

	task automatic loader_write(input string name, input logic [31:0] addr,
			input logic [31:0] data);
		fetch_pkg::apb_rsp_t rsp;
		loader_xfer(1'b1, addr, data, rsp);
		if (rsp.pslverr !== 1'b0) begin
			fail_run($sformatf("error %s write at %h expected pslverr 0 actual %b",
				name, addr, rsp.pslverr));
		end
	endtask

	task automatic loader_read(input string name, input logic [31:0] addr,
			input logic [31:0] exp_data);
		fetch_pkg::apb_rsp_t rsp;
		fetch_pkg::apb_rsp_t exp;
		loader_xfer(1'b0, addr, 32'h0, rsp);
		exp.prdata  = exp_data;
		exp.pready  = 1'b1;
		exp.pslverr = 1'b0;
		compare_rsp(name, exp, rsp);
	endtask

	// One-cycle flush, fetch restarts at addr
	task automatic redirect_to(input logic [31:0] addr);
		next_cycle();
		flush  = 1'b1;
		target = addr;
		// Nothing is presented in the flush cycle
		@(negedge clk);
		compare_stall("flush_stall", 1'b1, stall);
		next_cycle();
		flush  = 1'b0;
	endtask

	// Consecutive results from start, stepping by one word
	task automatic check_run(input string name, input logic [31:0] start, input int count);
		fetch_pkg::fetch_out_t res;
		for (int i = 0; i < count; i++) begin
			wait_fetch(name, res);
			compare_out(name, expect_at(start + i * 4), res);
		end
	endtask

	////////////////////////////////////////////////////////////
	// Directed tests
	////////////////////////////////////////////////////////////
	task automatic test_sequential();
		logic [31:0] w;
		// Program goes in while the core is frozen
		for (int i = 0; i < 16; i++) begin
			draw_word(w);
			prog[i] = w;
			loader_write("sequential_load", i * 4, w);
		end
		// Word read before the load is stale, restart at the reset vector
		next_cycle();
		flush  = 1'b1;
		target = RESET_PC;
		freeze = 1'b0;
		next_cycle();
		flush  = 1'b0;
		check_run("sequential", RESET_PC, 16);
	endtask

	task automatic test_freeze();
		fetch_pkg::fetch_out_t res;
		redirect_to(32'h10);
		wait_fetch("freeze", res);
		compare_out("freeze", expect_at(32'h10), res);
		next_cycle();
		freeze = 1'b1;
		// Arrives while frozen, then held
		wait_fetch("freeze", res);
		compare_out("freeze", expect_at(32'h14), res);
		repeat (10) begin
			@(negedge clk);
			compare_out("freeze_hold", expect_at(32'h14), fetch_out);
			compare_stall("freeze_hold", 1'b0, stall);
		end
		next_cycle();
		freeze = 1'b0;
		// Held word leaves in this cycle
		@(negedge clk);
		compare_out("freeze_release", expect_at(32'h14), fetch_out);
		wait_fetch("freeze_next", res);
		compare_out("freeze_next", expect_at(32'h18), res);
	endtask

	task automatic test_flush();
		// Next read is in its setup phase when the flush comes
		next_cycle();
		redirect_to(32'h20);
		check_run("flush", 32'h20, 2);
	endtask

	task automatic test_error_tags();
		fetch_pkg::fetch_out_t res;
		redirect_to(MEM_WORDS * 4);
		wait_fetch("bus_error", res);
		compare_out("bus_error", expect_at(MEM_WORDS * 4), res);
		redirect_to(PROT_BASE);
		wait_fetch("prot_error", res);
		compare_out("prot_error", expect_at(PROT_BASE), res);
	endtask

	task automatic test_squash();
		fetch_pkg::fetch_out_t res;
		fetch_pkg::fetch_out_t exp;
		next_cycle();
		squash = 1'b1;
		redirect_to(PROT_BASE);
		wait_fetch("squash", res);
		exp       = '0;
		exp.valid = 1'b1;
		exp.pc    = PROT_BASE;
		exp.insn  = fetch_pkg::NOP_INSN;
		compare_out("squash", exp, res);
		next_cycle();
		squash = 1'b0;
	endtask

	task automatic test_shared_port();
		logic [31:0] data [8];
		// Fetch keeps running under the loader traffic
		redirect_to(RESET_PC);
		for (int i = 0; i < 8; i++) begin
			draw_word(data[i]);
			loader_write("shared_write", 32'h80 + i * 4, data[i]);
		end
		for (int i = 0; i < 8; i++) begin
			loader_read("shared_read", 32'h80 + i * 4, data[i]);
		end
		redirect_to(RESET_PC);
		check_run("shared_fetch", RESET_PC, 16);
	endtask

	initial begin
		lfsr_q  = LFSR_SEED;
		reset_i = 1'b1;
		ld_req  = '0;
		freeze  = 1'b1;
		flush   = 1'b0;
		target  = '0;
		squash  = 1'b0;
		repeat (16) @(posedge clk);
		#1;
		reset_i = 1'b0;
		test_sequential();
		test_freeze();
		test_flush();
		test_error_tags();
		test_squash();
		test_shared_port();
		$display("sim passed");
		$finish;
	end

endmodule

`default_nettype wire
